// File: all.f
logic/tlb_pkg.sv
logic/plru_tree.sv
logic/tlb_entry_store.sv
logic/tlb_match.sv
logic/tlb_commit.sv
logic/tlb_wb_front.sv
logic/tlb_top.sv
dv/tlb_tb.sv

// File: Bender.yml
package:
  name: tlb

sources:
  # shared widths and codes, compiled first
  - files:
      - logic/tlb_pkg.sv

  # design
  - files:
      - logic/plru_tree.sv
      - logic/tlb_entry_store.sv
      - logic/tlb_match.sv
      - logic/tlb_commit.sv
      - logic/tlb_wb_front.sv
      - logic/tlb_top.sv

  # testbench
  - target: test
    files:
      - dv/tlb_tb.sv

// File: dv/tlb_stim.txt
# op vpn ppn expected, all values hex
# op: L lookup, I insert, F flush; expected = hit<<31 | idx<<16 | ppn
# empty after reset
L 000 000 00000000
L 123 000 00000000
# fill entries 0 to 7 in order
I 100 a00 00000a00
I 101 a01 00010a01
I 102 a02 00020a02
I 103 a03 00030a03
I 104 a04 00040a04
I 105 a05 00050a05
I 106 a06 00060a06
I 107 a07 00070a07
# hits steer the victim away from entry 0
L 103 000 80030a03
L 100 000 80000a00
L 105 000 80050a05
L 102 000 80020a02
# reinsert present vpn, new ppn
I 106 b06 80060b06
L 106 000 80060b06
# replacements follow the tree
I 200 c00 00010c00
L 101 000 00000000
L 200 000 80010c00
I 201 c01 00040c01
L 104 000 00000000
L 107 000 80070a07
L 103 000 80030a03
I 202 c02 00050c02
L 105 000 00000000
L 202 000 80050c02
# flush, then refill from the lowest free entry
F 000 000 00000000
L 100 000 00000000
L 202 000 00000000
I 300 d00 00000d00
I 301 d01 00010d01
L 300 000 80000d00
L 301 000 80010d01
I 302 d02 00020d02
L 302 000 80020d02
F 000 000 00000000
L 300 000 00000000
L 302 000 00000000

// File: dv/tlb_tb.sv
module tlb_tb
    import tlb_pkg::*;
();

    localparam int ClkPeriod   = 4;
    localparam int ResetCycles = 8;
    // acceptance edge to the edge that samples ack
    localparam int AckLatency  = 3;
    // give up on a missing ack after this many cycles
    localparam int AckLimit    = 8;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   cyc_i;
    logic                   stb_i;
    logic                   we_i;
    logic [WbAdrWidth-1:0]  adr_i;
    logic [WbDataWidth-1:0] dat_i;
    logic [WbDataWidth-1:0] dat_o;
    logic                   ack_o;

    // one entry per transaction, filled from the stimulus file
    logic [7:0]  op_q[$];
    logic [11:0] vpn_q[$];
    logic [11:0] ppn_q[$];
    logic [31:0] exp_q[$];

    int n_txn = 0;
    int n_done = 0;
    int data_errors = 0;
    int timing_errors = 0;
    int other_errors = 0;
    bit loaded = 1'b0;

    tlb_top uut (
        .clk_i, .rst_ni, .cyc_i, .stb_i, .we_i, .adr_i, .dat_i, .dat_o, .ack_o
    );

    always #(ClkPeriod / 2) clk_i = ~clk_i;

    // lines starting with # are comments, others are op vpn ppn expected
    task automatic load_stimulus();
        int         fd;
        int         code;
        int         n_fields;
        string      line;
        logic [7:0] op_c;
        logic [31:0] vpn_v;
        logic [31:0] ppn_v;
        logic [31:0] exp_v;
        fd = $fopen("dv/tlb_stim.txt", "r");
        assert (fd != 0)
        else begin
            $display("could not open the stimulus file dv/tlb_stim.txt");
            other_errors++;
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // skip blank lines and comments
                if (code != 0 && line.len() > 1 && line[0] != "#") begin
                    n_fields = $sscanf(line, "%c %h %h %h", op_c, vpn_v, ppn_v, exp_v);
                    assert (n_fields == 4 && (op_c == "L" || op_c == "I" || op_c == "F"))
                    else begin
                        $display("stimulus line could not be read: %s", line);
                        other_errors++;
                    end
                    if (n_fields == 4 && (op_c == "L" || op_c == "I" || op_c == "F")) begin
                        op_q.push_back(op_c);
                        vpn_q.push_back(vpn_v[11:0]);
                        ppn_q.push_back(ppn_v[11:0]);
                        exp_q.push_back(exp_v);
                    end
                end
            end
            $fclose(fd);
        end
        n_txn = op_q.size();
    endtask

    // one bus cycle: random idle gap, request, wait for ack, check, release
    task automatic run_transaction(int idx);
        int   gap;
        int   wait_cycles;
        logic acked;
        gap = $urandom % 4;
        repeat (gap) @(posedge clk_i);
        @(posedge clk_i);
        cyc_i <= 1'b1;
        stb_i <= 1'b1;
        case (op_q[idx])
            "L": begin
                we_i  <= 1'b0;
                adr_i <= {OpLookup, vpn_q[idx]};
                dat_i <= '0;
            end
            "I": begin
                we_i  <= 1'b1;
                adr_i <= {OpLookup, vpn_q[idx]};
                dat_i <= {20'd0, ppn_q[idx]};
            end
            default: begin
                we_i  <= 1'b1;
                adr_i <= {OpFlush, vpn_q[idx]};
                dat_i <= '0;
            end
        endcase
        // the dut samples the request here
        @(posedge clk_i);
        wait_cycles = 0;
        acked = 1'b0;
        // ack and dat_o are registered, look at them mid cycle
        while (!acked && wait_cycles < AckLimit) begin
            @(negedge clk_i);
            wait_cycles++;
            acked = ack_o;
        end
        assert (acked)
        else begin
            $display("no ack for transaction %0d within %0d cycles", idx, AckLimit);
            timing_errors++;
        end
        if (acked) begin
            assert (wait_cycles == AckLatency)
            else begin
                $display("ack for transaction %0d came %0d cycles after the request, not %0d",
                         idx, wait_cycles, AckLatency);
                timing_errors++;
            end
            assert (dat_o === exp_q[idx])
            else begin
                $display("Mismatch at %0t: dat_o got %08h expected %08h (transaction %0d)",
                         $time, dat_o, exp_q[idx], idx);
                data_errors++;
            end
        end
        // master drops the strobe once it has seen ack
        @(posedge clk_i);
        cyc_i <= 1'b0;
        stb_i <= 1'b0;
        we_i  <= 1'b0;
        n_done++;
    endtask

    task automatic finish_run();
        $display("errors: data %0d, timing %0d, other %0d",
                 data_errors, timing_errors, other_errors);
        if (data_errors + timing_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin
        int seed;
        seed = 12936;
        void'($urandom(seed));
        clk_i  = 1'b0;
        rst_ni = 1'b0;
        cyc_i  = 1'b0;
        stb_i  = 1'b0;
        we_i   = 1'b0;
        adr_i  = '0;
        dat_i  = '0;
        load_stimulus();
        loaded = 1'b1;
        repeat (ResetCycles) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int i = 0; i < n_txn; i++) begin
            run_transaction(i);
        end
        repeat (2) @(posedge clk_i);
        finish_run();
    end

    // each transaction needs at most 8 cycles, allow 10 plus reset
    initial begin
        wait (loaded);
        #((ResetCycles + n_txn * 10) * ClkPeriod);
        $display("watchdog timed out at %0t after %0d of %0d transactions",
                 $time, n_done, n_txn);
        other_errors++;
        finish_run();
    end

endmodule

// File: logic/tlb_top.sv
module tlb_top
    import tlb_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // wishbone classic slave
    input  logic                   cyc_i,
    input  logic                   stb_i,
    input  logic                   we_i,
    input  logic [WbAdrWidth-1:0]  adr_i,
    input  logic [WbDataWidth-1:0] dat_i,
    output logic [WbDataWidth-1:0] dat_o,
    output logic                   ack_o
);

    // front to match
    logic                                req_valid;
    logic                                req_write;
    logic [OpWidth-1:0]                  req_op;
    logic [VpnWidth-1:0]                 req_vpn;
    logic [PpnWidth-1:0]                 req_ppn;

    // match to commit
    logic                                m_valid;
    logic                                m_write;
    logic [OpWidth-1:0]                  m_op;
    logic [VpnWidth-1:0]                 m_vpn;
    logic [PpnWidth-1:0]                 m_ppn;
    logic [TlbEntries-1:0]               m_hit;

    // commit to store, plru and front
    logic                                wr_en;
    logic [TlbIdxWidth-1:0]              wr_idx;
    logic [VpnWidth-1:0]                 wr_vpn;
    logic [PpnWidth-1:0]                 wr_ppn;
    logic                                flush;
    logic [TlbEntries-1:0]               used;
    logic                                rsp_valid;
    logic [WbDataWidth-1:0]              rsp_data;

    // store and plru state
    logic [TlbEntries-1:0]               entry_valid;
    logic [TlbEntries-1:0][VpnWidth-1:0] entry_vpn;
    logic [TlbEntries-1:0][PpnWidth-1:0] entry_ppn;
    logic [TlbEntries-1:0]               plru;

    tlb_wb_front u_front (
        .clk_i, .rst_ni, .cyc_i, .stb_i, .we_i, .adr_i, .dat_i, .dat_o, .ack_o,
        .req_valid, .req_write, .req_op, .req_vpn, .req_ppn,
        .rsp_valid, .rsp_data
    );

    tlb_match u_match (
        .clk_i, .rst_ni,
        .req_valid, .req_write, .req_op, .req_vpn, .req_ppn,
        .entry_valid, .entry_vpn,
        .m_valid, .m_write, .m_op, .m_vpn, .m_ppn, .m_hit
    );

    tlb_commit u_commit (
        .clk_i, .rst_ni,
        .m_valid, .m_write, .m_op, .m_vpn, .m_ppn, .m_hit,
        .entry_valid, .entry_ppn, .plru,
        .wr_en, .wr_idx, .wr_vpn, .wr_ppn, .flush, .used,
        .rsp_valid, .rsp_data
    );

    tlb_entry_store u_store (
        .clk_i, .rst_ni, .wr_en, .wr_idx, .wr_vpn, .wr_ppn, .flush,
        .entry_valid, .entry_vpn, .entry_ppn
    );

    plru_tree #(.ENTRIES(TlbEntries)) u_plru (
        .clk_i, .rst_ni, .used_i(used), .plru_o(plru)
    );

endmodule

// File: logic/tlb_wb_front.sv
module tlb_wb_front
    import tlb_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // wishbone classic slave
    input  logic                   cyc_i,
    input  logic                   stb_i,
    input  logic                   we_i,
    input  logic [WbAdrWidth-1:0]  adr_i,
    input  logic [WbDataWidth-1:0] dat_i,
    output logic [WbDataWidth-1:0] dat_o,
    output logic                   ack_o,
    // request into the pipeline
    output logic                   req_valid,
    output logic                   req_write,
    output logic [OpWidth-1:0]     req_op,
    output logic [VpnWidth-1:0]    req_vpn,
    output logic [PpnWidth-1:0]    req_ppn,
    // response out of the pipeline
    input  logic                   rsp_valid,
    input  logic [WbDataWidth-1:0] rsp_data
);

    logic busy_q;
    logic accept;

    // new cycle only while idle, stb is ignored while an item is in flight
    assign accept = cyc_i && stb_i && !busy_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q    <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept;
            if (rsp_valid) begin
                busy_q <= 1'b0;
            end else if (accept) begin
                busy_q <= 1'b1;
            end
        end
    end

    // address split: op on top, vpn below
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_write <= we_i;
            req_op    <= adr_i[WbAdrWidth-1:VpnWidth];
            req_vpn   <= adr_i[VpnWidth-1:0];
            req_ppn   <= dat_i[PpnWidth-1:0];
        end
    end

    // rsp_valid is already a register, passed straight to the bus
    assign ack_o = rsp_valid;
    assign dat_o = ack_o ? rsp_data : '0;

    // busy keeps a second item out until the master has seen the ack
    assert property (@(posedge clk_i) disable iff (!rst_ni) ack_o |=> !ack_o)
    else $error("tlb_wb_front: ack held for two cycles");

endmodule

// File: logic/tlb_commit.sv
module tlb_commit
    import tlb_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_ni,
    // item from the match stage
    input  logic                                m_valid,
    input  logic                                m_write,
    input  logic [OpWidth-1:0]                  m_op,
    input  logic [VpnWidth-1:0]                 m_vpn,
    input  logic [PpnWidth-1:0]                 m_ppn,
    input  logic [TlbEntries-1:0]               m_hit,
    // store state and replacement candidate
    input  logic [TlbEntries-1:0]               entry_valid,
    input  logic [TlbEntries-1:0][PpnWidth-1:0] entry_ppn,
    input  logic [TlbEntries-1:0]               plru,
    // store write port and flush
    output logic                                wr_en,
    output logic [TlbIdxWidth-1:0]              wr_idx,
    output logic [VpnWidth-1:0]                 wr_vpn,
    output logic [PpnWidth-1:0]                 wr_ppn,
    output logic                                flush,
    // plru update
    output logic [TlbEntries-1:0]               used,
    // response back to the front
    output logic                                rsp_valid,
    output logic [WbDataWidth-1:0]              rsp_data
);

    logic                   any_hit;
    logic                   any_free;
    logic [TlbIdxWidth-1:0] hit_idx;
    logic [TlbIdxWidth-1:0] free_idx;
    logic [TlbIdxWidth-1:0] plru_idx;
    logic [TlbIdxWidth-1:0] tgt_idx;
    logic                   is_lookup;
    logic                   is_insert;
    logic                   is_flush;
    logic [WbDataWidth-1:0] rsp_d;

    assign any_hit  = |m_hit;
    assign any_free = ~&entry_valid;

    // one-hot to index, and lowest invalid entry by scanning downwards
    always_comb begin
        hit_idx  = '0;
        free_idx = '0;
        plru_idx = '0;
        for (int i = TlbEntries - 1; i >= 0; i--) begin
            if (m_hit[i]) hit_idx = TlbIdxWidth'(i);
            if (!entry_valid[i]) free_idx = TlbIdxWidth'(i);
            if (plru[i]) plru_idx = TlbIdxWidth'(i);
        end
    end

    // insert target: present entry, then a free one, then the plru victim
    assign tgt_idx = any_hit ? hit_idx : (any_free ? free_idx : plru_idx);

    assign is_lookup = m_valid && !m_write && (m_op == OpLookup);
    assign is_insert = m_valid && m_write && (m_op == OpLookup);
    assign is_flush  = m_valid && m_write && (m_op == OpFlush);

    // store side acts in the same cycle the response is registered
    assign wr_en  = is_insert;
    assign wr_idx = tgt_idx;
    assign wr_vpn = m_vpn;
    assign wr_ppn = m_ppn;
    assign flush  = is_flush;

    always_comb begin
        used  = '0;
        rsp_d = '0;
        if (is_lookup && any_hit) begin
            used                               = m_hit;
            rsp_d[RespHitBit]                  = 1'b1;
            rsp_d[RespIdxLsb +: TlbIdxWidth]   = hit_idx;
            rsp_d[PpnWidth-1:0]                = entry_ppn[hit_idx];
        end else if (is_insert) begin
            used[tgt_idx]                      = 1'b1;
            rsp_d[RespHitBit]                  = any_hit;
            rsp_d[RespIdxLsb +: TlbIdxWidth]   = tgt_idx;
            rsp_d[PpnWidth-1:0]                = m_ppn;
        end
        // miss, flush and unknown ops answer with zero
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= m_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (m_valid) begin
            rsp_data <= rsp_d;
        end
    end

    // the plru tree expects a single touched entry per cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(used))
    else $error("tlb_commit: more than one entry marked used");

endmodule

// File: logic/tlb_match.sv
module tlb_match
    import tlb_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_ni,
    // request from the bus front
    input  logic                                req_valid,
    input  logic                                req_write,
    input  logic [OpWidth-1:0]                  req_op,
    input  logic [VpnWidth-1:0]                 req_vpn,
    input  logic [PpnWidth-1:0]                 req_ppn,
    // current store contents
    input  logic [TlbEntries-1:0]               entry_valid,
    input  logic [TlbEntries-1:0][VpnWidth-1:0] entry_vpn,
    // registered request plus hit vector
    output logic                                m_valid,
    output logic                                m_write,
    output logic [OpWidth-1:0]                  m_op,
    output logic [VpnWidth-1:0]                 m_vpn,
    output logic [PpnWidth-1:0]                 m_ppn,
    output logic [TlbEntries-1:0]               m_hit
);

    logic [TlbEntries-1:0] hit_d;

    // fully associative compare, all tags in parallel
    always_comb begin
        for (int unsigned i = 0; i < TlbEntries; i++) begin
            hit_d[i] = entry_valid[i] && (entry_vpn[i] == req_vpn);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            m_valid <= 1'b0;
        end else begin
            m_valid <= req_valid;
        end
    end

    // payload, only looked at while m_valid is high
    always_ff @(posedge clk_i) begin
        if (req_valid) begin
            m_write <= req_write;
            m_op    <= req_op;
            m_vpn   <= req_vpn;
            m_ppn   <= req_ppn;
            m_hit   <= hit_d;
        end
    end

    // inserts reuse a hitting entry, so a vpn never lives twice in the store
    assert property (@(posedge clk_i) disable iff (!rst_ni) m_valid |-> $onehot0(m_hit))
    else $error("tlb_match: vpn found in more than one entry");

endmodule

// File: logic/tlb_entry_store.sv
module tlb_entry_store
    import tlb_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_ni,
    // single write port
    input  logic                                wr_en,
    input  logic [TlbIdxWidth-1:0]              wr_idx,
    input  logic [VpnWidth-1:0]                 wr_vpn,
    input  logic [PpnWidth-1:0]                 wr_ppn,
    // invalidate all entries
    input  logic                                flush,
    // full contents, read by match and commit
    output logic [TlbEntries-1:0]               entry_valid,
    output logic [TlbEntries-1:0][VpnWidth-1:0] entry_vpn,
    output logic [TlbEntries-1:0][PpnWidth-1:0] entry_ppn
);

    logic [TlbEntries-1:0]               valid_q;
    logic [TlbEntries-1:0][VpnWidth-1:0] vpn_q;
    logic [TlbEntries-1:0][PpnWidth-1:0] ppn_q;

    // valid bits, flush wins over nothing since both never coincide
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tags and ppns only change on a write
    // flush leaves them, valid gates every use
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            vpn_q[wr_idx] <= wr_vpn;
            ppn_q[wr_idx] <= wr_ppn;
        end
    end

    assign entry_valid = valid_q;
    assign entry_vpn   = vpn_q;
    assign entry_ppn   = ppn_q;

    // commit decodes one operation per item, so these are exclusive
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(wr_en && flush))
    else $error("tlb_entry_store: write and flush in the same cycle");

endmodule

// File: logic/plru_tree.sv
module plru_tree #(
    parameter int unsigned ENTRIES = 8
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    // entry i was touched this cycle, at most one bit
    input  logic [ENTRIES-1:0] used_i,
    // entry i is the one to replace next, exactly one bit
    output logic [ENTRIES-1:0] plru_o
);

    localparam int unsigned LogEntries = $clog2(ENTRIES);

    // tree nodes, heap ordered
    // node 0 is the root, children of node n are 2n+1 and 2n+2
    //
    //            0
    //          /   \
    //         1     2
    //        / \   / \
    //       3   4 5   6
    //
    // a node value of 0 points left, 1 points right
    logic [ENTRIES-2:0] tree_q;
    logic [ENTRIES-2:0] tree_d;

    // node on the path to entry i at level lvl
    function automatic int unsigned node_idx(int unsigned i, int unsigned lvl);
        return ((2 ** lvl) - 1) + (i >> (LogEntries - lvl));
    endfunction

    // branch taken at level lvl on the way to entry i, msb first
    function automatic logic path_bit(int unsigned i, int unsigned lvl);
        return 1'((i >> (LogEntries - lvl - 1)) & 1);
    endfunction

    // update
    // every node on the path of a used entry is turned to point
    // at the other half, so that entry becomes most recently used
    always_comb begin : tree_update
        tree_d = tree_q;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            if (used_i[i]) begin
                for (int unsigned lvl = 0; lvl < LogEntries; lvl++) begin
                    tree_d[node_idx(i, lvl)] = ~path_bit(i, lvl);
                end
            end
        end
    end

    // decode
    // an entry is the candidate when every node on its path
    // points the same way as the path itself
    always_comb begin : tree_decode
        plru_o = '1;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            for (int unsigned lvl = 0; lvl < LogEntries; lvl++) begin
                if (path_bit(i, lvl)) begin
                    plru_o[i] &= tree_q[node_idx(i, lvl)];
                end else begin
                    plru_o[i] &= ~tree_q[node_idx(i, lvl)];
                end
            end
        end
    end

    // all zero after reset, candidate is entry 0
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tree_q <= '0;
        end else begin
            tree_q <= tree_d;
        end
    end

    // the heap layout only works for a full binary tree
    initial begin
        assert (ENTRIES == 2 ** LogEntries)
        else $error("plru_tree: ENTRIES must be a power of two");
    end

endmodule

// File: logic/tlb_pkg.sv
package tlb_pkg;

    // number of translation entries, kept a power of two for the plru tree
    localparam int unsigned TlbEntries  = 8;
    localparam int unsigned TlbIdxWidth = $clog2(TlbEntries);

    // page number widths
    localparam int unsigned VpnWidth = 12;
    localparam int unsigned PpnWidth = 12;

    // wishbone widths, word addressed
    localparam int unsigned WbDataWidth = 32;
    localparam int unsigned WbAdrWidth  = 14;

    // the address bits above the vpn carry the operation
    localparam int unsigned OpWidth = WbAdrWidth - VpnWidth;

    // operation codes
    // a read with OpLookup is a lookup, a write with it is an insert
    localparam logic [OpWidth-1:0] OpLookup = 2'd0;
    // only meaningful on a write
    localparam logic [OpWidth-1:0] OpFlush  = 2'd1;

    // response word layout
    // hit bit means the vpn was already present
    localparam int unsigned RespHitBit = 31;
    // low bit of the entry index field
    localparam int unsigned RespIdxLsb = 16;
    // ppn sits in the low bits of the word, everything else is zero

endpackage
